// File: rtl/axi_cfg.svh
`ifndef AXI_CFG_SVH
`define AXI_CFG_SVH

// AXI4 read channel widths
`define AXI_ADDR_WIDTH 64
`define AXI_DATA_WIDTH 64
`define AXI_ID_WIDTH 4

// beats = len + 1
`define AXI_LEN_WIDTH 8

`define AXI_SIZE_WIDTH 3
`define AXI_RESP_WIDTH 2

// fixed IDs per requester, 4 bits wide to match AXI_ID_WIDTH
`define IFU_AXI_ID 4'd0
`define LSU_AXI_ID 4'd1

`endif

// File: rtl/axi_pkg.sv
package axi_pkg;

	typedef enum logic [1:0] {
		READ_IDLE = 2'b00,
		READ_ADDR = 2'b01,
		READ_DATA = 2'b10
	} read_state_e;

	typedef enum logic {
		OWNER_IFU = 1'b0,
		OWNER_LSU = 1'b1
	} owner_e;

	// request size, 1/2/4/8 bytes
	typedef enum logic [1:0] {
		SIZE_BYTE   = 2'b00,
		SIZE_HALF   = 2'b01,
		SIZE_WORD   = 2'b10,
		SIZE_DOUBLE = 2'b11
	} xfer_size_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_e;

endpackage

// File: rtl/read_arbiter.sv
`timescale 1ns/1ps
`include "axi_cfg.svh"

module read_arbiter (
	input  logic                         clk,
	input  logic                         reset_n,

	input  logic                         ifu_req_valid_i,
	input  logic [`AXI_ADDR_WIDTH-1:0]   ifu_addr_i,
	input  logic [`AXI_LEN_WIDTH-1:0]    ifu_len_i,
	input  axi_pkg::xfer_size_e          ifu_size_i,
	output logic                         ifu_req_ready_o,
	output logic                         ifu_r_valid_o,
	output logic [`AXI_DATA_WIDTH-1:0]   ifu_r_data_o,
	output axi_pkg::resp_e               ifu_r_resp_o,
	output logic                         ifu_r_last_o,

	input  logic                         lsu_req_valid_i,
	input  logic [`AXI_ADDR_WIDTH-1:0]   lsu_addr_i,
	input  logic [`AXI_LEN_WIDTH-1:0]    lsu_len_i,
	input  axi_pkg::xfer_size_e          lsu_size_i,
	output logic                         lsu_req_ready_o,
	output logic                         lsu_r_valid_o,
	output logic [`AXI_DATA_WIDTH-1:0]   lsu_r_data_o,
	output axi_pkg::resp_e               lsu_r_resp_o,
	output logic                         lsu_r_last_o,

	output logic                         m_ar_valid_o,
	output logic [`AXI_ID_WIDTH-1:0]     m_id_o,
	output logic [`AXI_ADDR_WIDTH-1:0]   m_addr_o,
	output logic [`AXI_LEN_WIDTH-1:0]    m_len_o,
	output axi_pkg::xfer_size_e          m_size_o,
	input  logic                         m_ar_ready_i,
	input  logic                         m_r_valid_i,
	input  logic [`AXI_DATA_WIDTH-1:0]   m_r_data_i,
	input  axi_pkg::resp_e               m_r_resp_i,
	input  logic                         m_r_last_i
);
	import axi_pkg::*;

	// last served requester, which also owns the burst in flight
	owner_e last_owner_q;
	owner_e grant;
	logic   accept;
	logic   ifu_owns;

	always_comb begin
		if (ifu_req_valid_i && lsu_req_valid_i) begin
			grant = (last_owner_q == OWNER_LSU) ? OWNER_IFU : OWNER_LSU;
		end else if (lsu_req_valid_i) begin
			grant = OWNER_LSU;
		end else begin
			grant = OWNER_IFU;
		end
	end

	assign accept = m_ar_valid_o && m_ar_ready_i;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			last_owner_q <= OWNER_LSU; // ifu wins the first tie
		end else if (accept) begin
			last_owner_q <= grant;
		end
	end

	// request mux toward the master
	assign m_ar_valid_o = ifu_req_valid_i || lsu_req_valid_i;
	assign m_id_o       = (grant == OWNER_IFU) ? `IFU_AXI_ID : `LSU_AXI_ID;
	assign m_addr_o     = (grant == OWNER_IFU) ? ifu_addr_i : lsu_addr_i;
	assign m_len_o      = (grant == OWNER_IFU) ? ifu_len_i : lsu_len_i;
	assign m_size_o     = (grant == OWNER_IFU) ? ifu_size_i : lsu_size_i;

	assign ifu_req_ready_o = m_ar_ready_i && (grant == OWNER_IFU);
	assign lsu_req_ready_o = m_ar_ready_i && (grant == OWNER_LSU);

	// response steering, only valid and last are gated
	assign ifu_owns = (last_owner_q == OWNER_IFU);

	assign ifu_r_valid_o = m_r_valid_i && ifu_owns;
	assign ifu_r_last_o  = m_r_last_i && ifu_owns;
	assign ifu_r_data_o  = m_r_data_i;
	assign ifu_r_resp_o  = m_r_resp_i;

	assign lsu_r_valid_o = m_r_valid_i && !ifu_owns;
	assign lsu_r_last_o  = m_r_last_i && !ifu_owns;
	assign lsu_r_data_o  = m_r_data_i;
	assign lsu_r_resp_o  = m_r_resp_i;

endmodule

// File: rtl/axi_read_master.sv
`timescale 1ns/1ps
`include "axi_cfg.svh"

module axi_read_master (
	input  logic                         clk,
	input  logic                         reset_n,

	input  logic                         cpu_ar_valid_i,
	input  logic [`AXI_ID_WIDTH-1:0]     cpu_id_i,
	input  logic [`AXI_ADDR_WIDTH-1:0]   cpu_addr_i,
	input  logic [`AXI_LEN_WIDTH-1:0]    cpu_len_i,
	input  axi_pkg::xfer_size_e          cpu_size_i,
	output logic                         cpu_ar_ready_o,
	output logic                         cpu_r_valid_o,
	output logic [`AXI_DATA_WIDTH-1:0]   cpu_r_data_o,
	output axi_pkg::resp_e               cpu_r_resp_o,
	output logic                         cpu_r_last_o,

	input  logic                         axi_ar_ready_i,
	output logic                         axi_ar_valid_o,
	output logic [`AXI_ID_WIDTH-1:0]     axi_ar_id_o,
	output logic [`AXI_ADDR_WIDTH-1:0]   axi_ar_addr_o,
	output logic [`AXI_LEN_WIDTH-1:0]    axi_ar_len_o,
	output logic [`AXI_SIZE_WIDTH-1:0]   axi_ar_size_o,

	output logic                         axi_r_ready_o,
	input  logic                         axi_r_valid_i,
	input  logic [`AXI_DATA_WIDTH-1:0]   axi_r_data_i,
	input  logic [`AXI_RESP_WIDTH-1:0]   axi_r_resp_i,
	input  logic                         axi_r_last_i
);
	import axi_pkg::*;

	read_state_e                 state_q;
	read_state_e                 state_d;
	logic                        accept;
	logic                        ar_hs;
	logic                        r_hs;
	xfer_size_e                  size_q;
	logic [2:0]                  offset_q; // byte offset inside the 8-byte word
	logic [`AXI_DATA_WIDTH-1:0]  size_mask;
	logic [`AXI_DATA_WIDTH-1:0]  lane_mask;

	assign cpu_ar_ready_o = (state_q == READ_IDLE);
	assign accept         = cpu_ar_valid_i && cpu_ar_ready_o;
	assign ar_hs          = axi_ar_valid_o && axi_ar_ready_i;
	assign axi_r_ready_o  = (state_q == READ_DATA);
	assign r_hs           = axi_r_valid_i && axi_r_ready_o;

	always_comb begin
		state_d = state_q;
		case (state_q)
			READ_IDLE: begin
				if (cpu_ar_valid_i) begin
					state_d = READ_ADDR;
				end
			end
			READ_ADDR: begin
				if (ar_hs) begin
					state_d = READ_DATA;
				end
			end
			READ_DATA: begin
				if (r_hs && axi_r_last_i) begin
					state_d = READ_IDLE;
				end
			end
			default: state_d = READ_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state_q        <= READ_IDLE;
			axi_ar_valid_o <= 1'b0;
		end else begin
			state_q        <= state_d;
			axi_ar_valid_o <= (state_d == READ_ADDR);
		end
	end

	// AR payload, held stable until the next accept
	always_ff @(posedge clk) begin
		if (accept) begin
			axi_ar_id_o   <= cpu_id_i;
			axi_ar_addr_o <= {cpu_addr_i[`AXI_ADDR_WIDTH-1:3], 3'b000};
			axi_ar_len_o  <= cpu_len_i;
			size_q        <= cpu_size_i;
			offset_q      <= cpu_addr_i[2:0];
		end
	end

	assign axi_ar_size_o = {1'b0, size_q}; // 2-bit size widened for AxSIZE

	always_comb begin
		case (size_q)
			SIZE_BYTE:   size_mask = {{(`AXI_DATA_WIDTH-8){1'b0}}, 8'hff};
			SIZE_HALF:   size_mask = {{(`AXI_DATA_WIDTH-16){1'b0}}, 16'hffff};
			SIZE_WORD:   size_mask = {{(`AXI_DATA_WIDTH-32){1'b0}}, 32'hffff_ffff};
			default:     size_mask = {`AXI_DATA_WIDTH{1'b1}};
		endcase
	end

	// bytes stay in their own lane
	assign lane_mask = size_mask << {offset_q, 3'b000};

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			cpu_r_valid_o <= 1'b0;
		end else begin
			cpu_r_valid_o <= r_hs; // one pulse per beat
		end
	end

	always_ff @(posedge clk) begin
		if (r_hs) begin
			cpu_r_data_o <= axi_r_data_i & lane_mask;
			cpu_r_resp_o <= resp_e'(axi_r_resp_i);
			cpu_r_last_o <= axi_r_last_i;
		end
	end

endmodule

// File: rtl/mem_read_top.sv
`timescale 1ns/1ps
`include "axi_cfg.svh"

module mem_read_top (
	input  logic                         clk,
	input  logic                         reset_n,

	input  logic                         ifu_req_valid_i,
	input  logic [`AXI_ADDR_WIDTH-1:0]   ifu_addr_i,
	input  logic [`AXI_LEN_WIDTH-1:0]    ifu_len_i,
	input  axi_pkg::xfer_size_e          ifu_size_i,
	output logic                         ifu_req_ready_o,
	output logic                         ifu_r_valid_o,
	output logic [`AXI_DATA_WIDTH-1:0]   ifu_r_data_o,
	output axi_pkg::resp_e               ifu_r_resp_o,
	output logic                         ifu_r_last_o,

	input  logic                         lsu_req_valid_i,
	input  logic [`AXI_ADDR_WIDTH-1:0]   lsu_addr_i,
	input  logic [`AXI_LEN_WIDTH-1:0]    lsu_len_i,
	input  axi_pkg::xfer_size_e          lsu_size_i,
	output logic                         lsu_req_ready_o,
	output logic                         lsu_r_valid_o,
	output logic [`AXI_DATA_WIDTH-1:0]   lsu_r_data_o,
	output axi_pkg::resp_e               lsu_r_resp_o,
	output logic                         lsu_r_last_o,

	input  logic                         axi_ar_ready_i,
	output logic                         axi_ar_valid_o,
	output logic [`AXI_ID_WIDTH-1:0]     axi_ar_id_o,
	output logic [`AXI_ADDR_WIDTH-1:0]   axi_ar_addr_o,
	output logic [`AXI_LEN_WIDTH-1:0]    axi_ar_len_o,
	output logic [`AXI_SIZE_WIDTH-1:0]   axi_ar_size_o,
	output logic                         axi_r_ready_o,
	input  logic                         axi_r_valid_i,
	input  logic [`AXI_DATA_WIDTH-1:0]   axi_r_data_i,
	input  logic [`AXI_RESP_WIDTH-1:0]   axi_r_resp_i,
	input  logic                         axi_r_last_i
);
	import axi_pkg::*;

	// arbiter to master
	logic                        m_ar_valid;
	logic [`AXI_ID_WIDTH-1:0]    m_id;
	logic [`AXI_ADDR_WIDTH-1:0]  m_addr;
	logic [`AXI_LEN_WIDTH-1:0]   m_len;
	xfer_size_e                  m_size;
	logic                        m_ar_ready;
	logic                        m_r_valid;
	logic [`AXI_DATA_WIDTH-1:0]  m_r_data;
	resp_e                       m_r_resp;
	logic                        m_r_last;

	read_arbiter arb_i (
		.clk             (clk),
		.reset_n         (reset_n),
		.ifu_req_valid_i (ifu_req_valid_i),
		.ifu_addr_i      (ifu_addr_i),
		.ifu_len_i       (ifu_len_i),
		.ifu_size_i      (ifu_size_i),
		.ifu_req_ready_o (ifu_req_ready_o),
		.ifu_r_valid_o   (ifu_r_valid_o),
		.ifu_r_data_o    (ifu_r_data_o),
		.ifu_r_resp_o    (ifu_r_resp_o),
		.ifu_r_last_o    (ifu_r_last_o),
		.lsu_req_valid_i (lsu_req_valid_i),
		.lsu_addr_i      (lsu_addr_i),
		.lsu_len_i       (lsu_len_i),
		.lsu_size_i      (lsu_size_i),
		.lsu_req_ready_o (lsu_req_ready_o),
		.lsu_r_valid_o   (lsu_r_valid_o),
		.lsu_r_data_o    (lsu_r_data_o),
		.lsu_r_resp_o    (lsu_r_resp_o),
		.lsu_r_last_o    (lsu_r_last_o),
		.m_ar_valid_o    (m_ar_valid),
		.m_id_o          (m_id),
		.m_addr_o        (m_addr),
		.m_len_o         (m_len),
		.m_size_o        (m_size),
		.m_ar_ready_i    (m_ar_ready),
		.m_r_valid_i     (m_r_valid),
		.m_r_data_i      (m_r_data),
		.m_r_resp_i      (m_r_resp),
		.m_r_last_i      (m_r_last)
	);

	axi_read_master master_i (
		.clk            (clk),
		.reset_n        (reset_n),
		.cpu_ar_valid_i (m_ar_valid),
		.cpu_id_i       (m_id),
		.cpu_addr_i     (m_addr),
		.cpu_len_i      (m_len),
		.cpu_size_i     (m_size),
		.cpu_ar_ready_o (m_ar_ready),
		.cpu_r_valid_o  (m_r_valid),
		.cpu_r_data_o   (m_r_data),
		.cpu_r_resp_o   (m_r_resp),
		.cpu_r_last_o   (m_r_last),
		.axi_ar_ready_i (axi_ar_ready_i),
		.axi_ar_valid_o (axi_ar_valid_o),
		.axi_ar_id_o    (axi_ar_id_o),
		.axi_ar_addr_o  (axi_ar_addr_o),
		.axi_ar_len_o   (axi_ar_len_o),
		.axi_ar_size_o  (axi_ar_size_o),
		.axi_r_ready_o  (axi_r_ready_o),
		.axi_r_valid_i  (axi_r_valid_i),
		.axi_r_data_i   (axi_r_data_i),
		.axi_r_resp_i   (axi_r_resp_i),
		.axi_r_last_i   (axi_r_last_i)
	);

endmodule

// File: tb/tb_mem_read_top.sv
`timescale 1ns/1ps
`include "axi_cfg.svh"

module tb_mem_read_top;
	import axi_pkg::*;

	localparam int CLK_PERIOD      = 40;
	localparam int NUM_TESTS       = 6;
	localparam int CYCLES_PER_TEST = 200;
	localparam logic [`AXI_ADDR_WIDTH-1:0] ERR_BASE = 64'h8000_0000_0000_0000;

	logic                        clk;
	logic                        reset_n;
	logic                        ifu_req_valid_i, lsu_req_valid_i;
	logic [`AXI_ADDR_WIDTH-1:0]  ifu_addr_i, lsu_addr_i;
	logic [`AXI_LEN_WIDTH-1:0]   ifu_len_i, lsu_len_i;
	xfer_size_e                  ifu_size_i, lsu_size_i;
	logic                        ifu_req_ready_o, lsu_req_ready_o;
	logic                        ifu_r_valid_o, lsu_r_valid_o;
	logic                        ifu_r_last_o, lsu_r_last_o;
	logic [`AXI_DATA_WIDTH-1:0]  ifu_r_data_o, lsu_r_data_o;
	resp_e                       ifu_r_resp_o, lsu_r_resp_o;
	logic                        axi_ar_ready_i, axi_ar_valid_o;
	logic                        axi_r_ready_o, axi_r_valid_i, axi_r_last_i;
	logic [`AXI_ID_WIDTH-1:0]    axi_ar_id_o;
	logic [`AXI_ADDR_WIDTH-1:0]  axi_ar_addr_o;
	logic [`AXI_LEN_WIDTH-1:0]   axi_ar_len_o;
	logic [`AXI_SIZE_WIDTH-1:0]  axi_ar_size_o;
	logic [`AXI_DATA_WIDTH-1:0]  axi_r_data_i;
	logic [`AXI_RESP_WIDTH-1:0]  axi_r_resp_i;

	logic [31:0]                 lfsr_q;
	logic                        random_stall;
	string                       cur_test;
	int                          errors, checks, pulse_count, r_hs_count;
	logic [66:0]                 ifu_beats[$], lsu_beats[$]; // {last, resp, data}
	logic [`AXI_ID_WIDTH-1:0]    ar_id_q[$];
	// slave model, AR fields of the current burst
	logic                        sl_busy, ar_seen;
	logic [`AXI_LEN_WIDTH-1:0]   sl_beat;
	logic [`AXI_ID_WIDTH-1:0]    held_id;
	logic [`AXI_ADDR_WIDTH-1:0]  held_addr;
	logic [`AXI_LEN_WIDTH-1:0]   held_len;
	logic [`AXI_SIZE_WIDTH-1:0]  held_size;

	mem_read_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
		$display("timeout after %0d cycles, a test is stuck", NUM_TESTS * CYCLES_PER_TEST);
		$display("Simulation FAILED");
		$finish;
	end

	function automatic logic lfsr_bit();
		logic b;
		b = lfsr_q[0];
		lfsr_q = lfsr_q >> 1;
		if (b)
			lfsr_q = lfsr_q ^ 32'h8020_0003;
		return b;
	endfunction

	function automatic logic [7:0] lfsr_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[6:0], lfsr_bit()};
		return v;
	endfunction

	// beat address mixed into a data word
	function automatic logic [63:0] model_word(input logic [63:0] a);
		return (a * 64'h9e37_79b9_7f4a_7c15) ^ {a[31:0], ~a[63:32]};
	endfunction

	function automatic resp_e model_resp(input logic [63:0] a);
		return (a >= ERR_BASE) ? RESP_SLVERR : RESP_OKAY;
	endfunction

	// keeps bytes offset .. offset+size-1 in their lanes
	function automatic logic [63:0] lane_bytes(input xfer_size_e size, input logic [2:0] offset);
		logic [63:0] m;
		int          nbytes;
		nbytes = 1 << int'(size);
		m = '0;
		for (int i = 0; i < 8; i++)
			if (i >= offset && i < offset + nbytes)
				m[i*8 +: 8] = 8'hff;
		return m;
	endfunction

	task automatic compare_value(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		checks++;
		assert (actual === expected) else begin
			$display("CHECK FAILED %s %s: expected %h actual %h",
				cur_test, what, expected, actual);
			errors++;
		end
	endtask

	// AXI slave, drives on the falling edge
	always @(negedge clk) begin
		if (!reset_n) begin
			axi_ar_ready_i = 1'b0;
			axi_r_valid_i  = 1'b0;
			axi_r_last_i   = 1'b0;
			sl_busy        = 1'b0;
			ar_seen        = 1'b0;
		end else begin
			if (axi_r_valid_i) begin // taken at the last posedge
				r_hs_count++;
				sl_busy = !axi_r_last_i;
				sl_beat++;
			end
			axi_r_valid_i = 1'b0;
			axi_r_last_i  = 1'b0;
			if (sl_busy && axi_r_ready_o && !(random_stall && lfsr_bit())) begin
				axi_r_valid_i = 1'b1;
				axi_r_data_i  = model_word(held_addr + 8 * sl_beat);
				axi_r_resp_i  = model_resp(held_addr + 8 * sl_beat);
				axi_r_last_i  = (sl_beat == held_len);
			end
			if (axi_ar_ready_i) begin
				axi_ar_ready_i = 1'b0;
				ar_seen        = 1'b0;
			end else if (axi_ar_valid_o) begin
				if (ar_seen) begin
					compare_value("AR addr held", held_addr, axi_ar_addr_o);
					compare_value("AR id/len/size held", {held_id, held_len, held_size},
						{axi_ar_id_o, axi_ar_len_o, axi_ar_size_o});
				end
				held_id   = axi_ar_id_o;
				held_addr = axi_ar_addr_o;
				held_len  = axi_ar_len_o;
				held_size = axi_ar_size_o;
				ar_seen   = 1'b1;
				if (!(random_stall && lfsr_bit())) begin
					axi_ar_ready_i = 1'b1;
					sl_busy        = 1'b1;
					sl_beat        = '0;
					ar_id_q.push_back(axi_ar_id_o);
				end
			end
		end
	end

	always @(negedge clk) begin
		if (ifu_r_valid_o === 1'b1) begin
			ifu_beats.push_back({ifu_r_last_o, ifu_r_resp_o, ifu_r_data_o});
			pulse_count++;
		end
		if (lsu_r_valid_o === 1'b1) begin
			lsu_beats.push_back({lsu_r_last_o, lsu_r_resp_o, lsu_r_data_o});
			pulse_count++;
		end
	end

	task automatic send_request(input owner_e who, input logic [63:0] addr,
			input logic [7:0] len, input xfer_size_e size);
		logic taken;
		taken = 1'b0;
		@(negedge clk);
		if (who == OWNER_IFU) begin
			ifu_req_valid_i = 1'b1;
			ifu_addr_i      = addr;
			ifu_len_i       = len;
			ifu_size_i      = size;
		end else begin
			lsu_req_valid_i = 1'b1;
			lsu_addr_i      = addr;
			lsu_len_i       = len;
			lsu_size_i      = size;
		end
		while (!taken) begin
			#1;
			taken = (who == OWNER_IFU) ? ifu_req_ready_o : lsu_req_ready_o;
			@(negedge clk);
		end
		if (who == OWNER_IFU)
			ifu_req_valid_i = 1'b0;
		else
			lsu_req_valid_i = 1'b0;
	endtask

	task automatic wait_beats(input owner_e who, input int count);
		while (((who == OWNER_IFU) ? ifu_beats.size() : lsu_beats.size()) < count)
			@(negedge clk);
	endtask

	task automatic check_beats(input owner_e who, input logic [63:0] addr,
			input logic [7:0] len, input xfer_size_e size);
		logic [66:0] beat;
		logic [63:0] base;
		logic [63:0] mask;
		logic [3:0]  exp_id;
		base   = {addr[63:3], 3'b000};
		mask   = lane_bytes(size, addr[2:0]);
		exp_id = (who == OWNER_IFU) ? `IFU_AXI_ID : `LSU_AXI_ID;
		wait_beats(who, len + 1);
		repeat (3) @(negedge clk); // no extra pulses may follow
		compare_value("AR addr", base, held_addr);
		compare_value("AR id", exp_id, held_id);
		compare_value("AR len", len, held_len);
		compare_value("AR size", size, held_size);
		compare_value("beat count", len + 1,
			(who == OWNER_IFU) ? ifu_beats.size() : lsu_beats.size());
		compare_value("pulses to other requester", 0,
			(who == OWNER_IFU) ? lsu_beats.size() : ifu_beats.size());
		compare_value("pulses vs R handshakes", r_hs_count, pulse_count);
		for (int k = 0; k <= len; k++) begin
			beat = (who == OWNER_IFU) ? ifu_beats[k] : lsu_beats[k];
			compare_value("data", model_word(base + 8 * k) & mask, beat[63:0]);
			compare_value("resp", model_resp(base + 8 * k), beat[65:64]);
			compare_value("last", k == len, beat[66]);
		end
		ifu_beats.delete();
		lsu_beats.delete();
	endtask

	task automatic read_and_check(input owner_e who, input logic [63:0] addr,
			input logic [7:0] len, input xfer_size_e size);
		send_request(who, addr, len, size);
		check_beats(who, addr, len, size);
	endtask

	task automatic test_reset_accept();
		cur_test = "reset_accept";
		compare_value("axi_ar_valid_o", 0, axi_ar_valid_o);
		compare_value("axi_r_ready_o", 0, axi_r_ready_o);
		compare_value("ifu_r_valid_o", 0, ifu_r_valid_o);
		compare_value("lsu_r_valid_o", 0, lsu_r_valid_o);
		@(negedge clk);
		ifu_req_valid_i = 1'b1;
		ifu_addr_i      = 64'h100;
		ifu_len_i       = 8'd0;
		ifu_size_i      = SIZE_DOUBLE;
		#1;
		compare_value("ifu_req_ready_o", 1, ifu_req_ready_o);
		compare_value("axi_ar_valid_o before accept", 0, axi_ar_valid_o);
		@(negedge clk);
		ifu_req_valid_i = 1'b0;
		compare_value("axi_ar_valid_o after accept", 1, axi_ar_valid_o);
		check_beats(OWNER_IFU, 64'h100, 8'd0, SIZE_DOUBLE);
	endtask

	task automatic test_ifu_sizes();
		cur_test = "ifu_sizes";
		for (int s = 0; s < 4; s++)
			for (int off = 0; off < 8; off += (1 << s))
				read_and_check(OWNER_IFU, 64'h4000 + 64'h40 * s + off, 8'd0, xfer_size_e'(s));
	endtask

	task automatic test_lsu_bursts();
		cur_test = "lsu_bursts";
		read_and_check(OWNER_LSU, 64'h3004, 8'd3, SIZE_WORD);
		read_and_check(OWNER_LSU, 64'h5002, 8'd7, SIZE_HALF);
	endtask

	task automatic test_slave_error();
		cur_test = "slave_error";
		read_and_check(OWNER_LSU, ERR_BASE + 64'h1240, 8'd2, SIZE_DOUBLE);
	endtask

	task automatic test_interleave();
		cur_test = "interleave";
		ar_id_q.delete();
		fork
			for (int i = 0; i < 4; i++)
				send_request(OWNER_IFU, 64'h1000 + 8 * i, 8'd0, SIZE_DOUBLE);
			for (int i = 0; i < 4; i++)
				send_request(OWNER_LSU, 64'h2000 + 8 * i, 8'd0, SIZE_DOUBLE);
		join
		wait_beats(OWNER_IFU, 4);
		wait_beats(OWNER_LSU, 4);
		repeat (3) @(negedge clk);
		compare_value("AR count", 8, ar_id_q.size());
		compare_value("ifu beat count", 4, ifu_beats.size());
		compare_value("lsu beat count", 4, lsu_beats.size());
		for (int i = 0; i < 8; i++)
			compare_value("AR id order", (i % 2 == 0) ? `IFU_AXI_ID : `LSU_AXI_ID, ar_id_q[i]);
		for (int i = 0; i < 4; i++) begin
			compare_value("ifu data", model_word(64'h1000 + 8 * i), ifu_beats[i][63:0]);
			compare_value("lsu data", model_word(64'h2000 + 8 * i), lsu_beats[i][63:0]);
		end
		ifu_beats.delete();
		lsu_beats.delete();
	endtask

	task automatic test_random_stall();
		owner_e      who[6];
		logic [7:0]  len[6];
		xfer_size_e  size[6];
		logic [63:0] addr[6];
		logic [7:0]  r;
		cur_test = "random_stall";
		// all parameters drawn before the slave starts stepping the LFSR
		for (int i = 0; i < 6; i++) begin
			who[i]  = owner_e'(lfsr_bit());
			len[i]  = lfsr_bits(3);
			r       = lfsr_bits(2);
			size[i] = xfer_size_e'(r[1:0]);
			r       = lfsr_bits(3);
			addr[i] = 64'h9000 + 64'h100 * i + (r[2:0] & ~((3'd1 << size[i]) - 3'd1));
		end
		random_stall = 1'b1;
		for (int i = 0; i < 6; i++)
			read_and_check(who[i], addr[i], len[i], size[i]);
		random_stall = 1'b0;
	endtask

	initial begin
		reset_n         = 1'b0;
		ifu_req_valid_i = 1'b0;
		ifu_addr_i      = '0;
		ifu_len_i       = '0;
		ifu_size_i      = SIZE_BYTE;
		lsu_req_valid_i = 1'b0;
		lsu_addr_i      = '0;
		lsu_len_i       = '0;
		lsu_size_i      = SIZE_BYTE;
		axi_ar_ready_i  = 1'b0;
		axi_r_valid_i   = 1'b0;
		axi_r_data_i    = '0;
		axi_r_resp_i    = '0;
		axi_r_last_i    = 1'b0;
		lfsr_q          = 32'h142b_a9ae;
		random_stall    = 1'b0;
		errors          = 0;
		checks          = 0;
		pulse_count     = 0;
		r_hs_count      = 0;
		cur_test        = "reset";
		repeat (8) @(negedge clk);
		reset_n = 1'b1;
		test_reset_accept();
		test_ifu_sizes();
		test_lsu_bursts();
		test_slave_error(); // leaves lsu as last served
		test_interleave();
		test_random_stall();
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: files.f
+incdir+rtl
rtl/axi_pkg.sv
rtl/read_arbiter.sv
rtl/axi_read_master.sv
rtl/mem_read_top.sv
tb/tb_mem_read_top.sv

// File: Bender.yml
package:
  name: mem_read

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/axi_pkg.sv
      - rtl/read_arbiter.sv
      - rtl/axi_read_master.sv
      - rtl/mem_read_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - tb/tb_mem_read_top.sv
